// File: src/mips_isa_pkg.sv
package mips_isa_pkg;

    // Primary opcodes in instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_beq     = 6'h04,
        op_addiu   = 6'h09,
        op_lw      = 6'h23,
        op_sb      = 6'h28,
        op_sw      = 6'h2b
    } opcode_t;

    // Function codes of op_special in instr[5:0]
    typedef enum logic [5:0] {
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25
    } funct_t;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or
    } alu_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_execute,
        st_mem,
        st_writeback,
        st_halt
    } cpu_state_t;

    localparam logic [4:0] reg_v0 = 5'd2;  // Result register

    function automatic logic [5:0] get_opcode(input logic [31:0] instr);
        return instr[31:26];
    endfunction

    function automatic logic [4:0] get_rs(input logic [31:0] instr);
        return instr[25:21];
    endfunction

    function automatic logic [4:0] get_rt(input logic [31:0] instr);
        return instr[20:16];
    endfunction

    function automatic logic [4:0] get_rd(input logic [31:0] instr);
        return instr[15:11];
    endfunction

    function automatic logic [5:0] get_funct(input logic [31:0] instr);
        return instr[5:0];
    endfunction

    // Sign extended 16-bit immediate
    function automatic logic [31:0] sign_ext_imm(input logic [31:0] instr);
        return {{16{instr[15]}}, instr[15:0]};
    endfunction

endpackage

// File: src/avalon_bus_pkg.sv
package avalon_bus_pkg;

    localparam int addr_bits  = 32;
    localparam int data_bits  = 32;
    localparam int byte_bits  = 8;
    localparam int byte_lanes = data_bits / byte_bits;  // Lanes per word

    typedef logic [addr_bits-1:0]  addr_t;
    typedef logic [data_bits-1:0]  data_t;
    typedef logic [byte_lanes-1:0] byte_en_t;

    // Full word access
    localparam byte_en_t byte_en_word = '1;
    // No lane selected while the bus is idle
    localparam byte_en_t byte_en_none = '0;

endpackage

// File: src/avalon_mm_if.sv
`timescale 1ns/10ps

interface avalon_mm_if
    import avalon_bus_pkg::*;
();

    addr_t    address;
    logic     read;
    logic     write;
    data_t    writedata;
    byte_en_t byteenable;
    data_t    readdata;
    logic     waitrequest;   // Slave stretches the transfer

    modport master (
        output address,
        output read,
        output write,
        output writedata,
        output byteenable,
        input  readdata,
        input  waitrequest
    );

    modport slave (
        input  address,
        input  read,
        input  write,
        input  writedata,
        input  byteenable,
        output readdata,
        output waitrequest
    );

endinterface

// File: src/mips_alu.sv
`timescale 1ns/10ps

module mips_alu
    import mips_isa_pkg::*;
    import avalon_bus_pkg::*;
(
    input  alu_op_t op,
    input  data_t   a,
    input  data_t   b,
    output data_t   result,
    output logic    zero
);

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;  // addu, addiu and address calculation
            end
            alu_sub: begin
                result = a - b;  // subu and beq compare
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            default: begin
                result = a + b;
            end
        endcase
    end

    // Equal operands give zero on alu_sub
    assign zero = (result == '0);

endmodule

// File: src/mips_reg_file.sv
`timescale 1ns/10ps

module mips_reg_file
    import mips_isa_pkg::*;
    import avalon_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [4:0] rs_addr,
    input  logic [4:0] rt_addr,
    output data_t      rs_data,
    output data_t      rt_data,
    input  logic       wr_en,
    input  logic [4:0] wr_addr,
    input  data_t      wr_data,
    output data_t      v0
);

    data_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;  // $zero never written
        end
    end

    // Asynchronous read ports
    assign rs_data = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? '0 : regs[rt_addr];

    assign v0 = regs[reg_v0];  // Observed at top level

endmodule

// File: src/mips_cpu.sv
`timescale 1ns/10ps

module mips_cpu
    import mips_isa_pkg::*;
    import avalon_bus_pkg::*;
#(
    parameter addr_t reset_vector = 32'd4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    output logic        active,
    output data_t       register_v0,
    avalon_mm_if.master bus
);

    cpu_state_t state;
    addr_t      pc;
    data_t      ir;          // Instruction register
    data_t      a_reg;       // rs operand
    data_t      b_reg;       // rt operand
    data_t      alu_out;
    data_t      mdr;         // Load data

    opcode_t    opcode;
    funct_t     funct;
    data_t      imm_ext;
    data_t      rs_data;
    data_t      rt_data;
    alu_op_t    alu_op;
    data_t      alu_b;
    data_t      alu_result;
    logic       alu_zero;
    logic       uses_imm;
    logic       wr_en;
    logic [4:0] wr_addr;
    data_t      wr_data;
    logic [1:0] sb_lane;

    assign opcode  = opcode_t'(get_opcode(ir));
    assign funct   = funct_t'(get_funct(ir));
    assign imm_ext = sign_ext_imm(ir);
    assign sb_lane = alu_out[1:0];  // Byte lane of sb

    mips_reg_file i_reg_file (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (get_rs(ir)),
        .rt_addr (get_rt(ir)),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .v0      (register_v0)
    );

    mips_alu i_alu (
        .op     (alu_op),
        .a      (a_reg),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // ALU control
    always_comb begin
        uses_imm = 1'b1;
        alu_op   = alu_add;
        case (opcode)
            op_special: begin
                uses_imm = 1'b0;
                case (funct)
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    default: alu_op = alu_add;
                endcase
            end
            op_beq: begin
                uses_imm = 1'b0;
                alu_op   = alu_sub;
            end
            default: ;
        endcase
    end

    assign alu_b = uses_imm ? imm_ext : b_reg;

    // Register write in st_writeback only
    always_comb begin
        wr_en   = 1'b0;
        wr_addr = get_rt(ir);
        wr_data = alu_out;
        if (state == st_writeback) begin
            case (opcode)
                op_addiu: wr_en = 1'b1;
                op_lw: begin
                    wr_en   = 1'b1;
                    wr_data = mdr;
                end
                op_special: begin
                    wr_addr = get_rd(ir);
                    wr_en   = funct inside {fn_addu, fn_subu, fn_and, fn_or};
                end
                default: ;  // Unknown opcodes write nothing
            endcase
        end
    end

    // Bus request held steady by the state while waitrequest is high
    always_comb begin
        bus.address    = pc;
        bus.read       = 1'b0;
        bus.write      = 1'b0;
        bus.writedata  = b_reg;
        bus.byteenable = byte_en_none;
        if (state == st_fetch) begin
            bus.read       = 1'b1;
            bus.byteenable = byte_en_word;
        end else if (state == st_mem) begin
            bus.address = alu_out;
            case (opcode)
                op_lw: begin
                    bus.read       = 1'b1;
                    bus.byteenable = byte_en_word;
                end
                op_sw: begin
                    bus.write      = 1'b1;
                    bus.byteenable = byte_en_word;
                end
                op_sb: begin
                    bus.write      = 1'b1;
                    bus.writedata  = {byte_lanes{b_reg[7:0]}};  // Same byte on every lane
                    bus.byteenable = byte_en_t'(1) << sb_lane;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            pc     <= '0;
            active <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state  <= st_fetch;
                        pc     <= reset_vector;
                        active <= 1'b1;
                    end
                end
                st_fetch: begin
                    if (!bus.waitrequest) begin
                        pc    <= pc + 32'd4;
                        state <= st_decode;
                    end
                end
                st_decode: state <= st_execute;
                st_execute: begin
                    state <= st_writeback;
                    case (opcode)
                        op_lw, op_sw, op_sb: state <= st_mem;
                        op_beq: begin
                            // No delay slot so pc already points past the beq
                            if (alu_zero) begin
                                pc <= pc + (imm_ext << 2);
                            end
                        end
                        op_special: begin
                            if (funct == fn_jr) begin
                                if (a_reg == '0) begin
                                    state  <= st_halt;  // End of program
                                    active <= 1'b0;
                                end else begin
                                    pc <= a_reg;
                                end
                            end
                        end
                        default: ;
                    endcase
                end
                st_mem: begin
                    if (!bus.waitrequest) begin
                        state <= st_writeback;
                    end
                end
                st_writeback: state <= st_fetch;
                st_halt:      state <= st_halt;  // Left only by reset
                default:      state <= st_idle;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (state == st_fetch && !bus.waitrequest) begin
            ir <= bus.readdata;
        end
        if (state == st_decode) begin
            a_reg <= rs_data;
            b_reg <= rt_data;
        end
        if (state == st_execute) begin
            alu_out <= alu_result;
        end
        if (state == st_mem && !bus.waitrequest) begin
            mdr <= bus.readdata;
        end
    end

endmodule

// File: src/avalon_ram.sv
`timescale 1ns/10ps

module avalon_ram
    import avalon_bus_pkg::*;
#(
    parameter int ram_addr_bits = 8,
    parameter int wait_cycles   = 1
) (
    input  logic       clk,
    input  logic       rst,
    avalon_mm_if.slave bus,
    input  logic       load_en,
    input  addr_t      load_addr,
    input  data_t      load_data
);

    localparam int depth    = 1 << ram_addr_bits;
    // One spare bit keeps the counter valid for zero wait cycles
    localparam int cnt_bits = $clog2(wait_cycles + 2);

    data_t                    mem [depth];
    logic [cnt_bits-1:0]      wait_cnt;
    logic                     request;
    logic [ram_addr_bits-1:0] bus_index;
    logic [ram_addr_bits-1:0] load_index;

    assign request    = bus.read || bus.write;
    assign bus_index  = bus.address[ram_addr_bits+1:2];  // Word address
    assign load_index = load_addr[ram_addr_bits+1:2];

    // Low for one cycle once the count reaches wait_cycles
    assign bus.waitrequest = request && (wait_cnt != cnt_bits'(wait_cycles));
    assign bus.readdata    = mem[bus_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (request && bus.waitrequest) begin
            wait_cnt <= wait_cnt + cnt_bits'(1);
        end else begin
            wait_cnt <= '0;  // Restart for the next request
        end
    end

    // The loader has priority over bus writes
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_index] <= load_data;
        end else if (bus.write && !bus.waitrequest) begin
            for (int i = 0; i < byte_lanes; i++) begin
                if (bus.byteenable[i]) begin
                    mem[bus_index][byte_bits*i +: byte_bits] <=
                        bus.writedata[byte_bits*i +: byte_bits];
                end
            end
        end
    end

endmodule

// File: src/mips_system.sv
`timescale 1ns/10ps

module mips_system
    import avalon_bus_pkg::*;
#(
    parameter addr_t reset_vector  = 32'd4,
    parameter int    ram_addr_bits = 8,
    parameter int    wait_cycles   = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  logic     load_en,
    input  addr_t    load_addr,
    input  data_t    load_data,
    output logic     active,
    output data_t    register_v0,
    output addr_t    bus_address,
    output logic     bus_read,
    output logic     bus_write,
    output data_t    bus_writedata,
    output byte_en_t bus_byteenable
);

    avalon_mm_if bus_if ();

    mips_cpu #(
        .reset_vector (reset_vector)
    ) i_cpu (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .active      (active),
        .register_v0 (register_v0),
        .bus         (bus_if.master)
    );

    avalon_ram #(
        .ram_addr_bits (ram_addr_bits),
        .wait_cycles   (wait_cycles)
    ) i_ram (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus_if.slave),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    // Bus copies for observation
    assign bus_address    = bus_if.address;
    assign bus_read       = bus_if.read;
    assign bus_write      = bus_if.write;
    assign bus_writedata  = bus_if.writedata;
    assign bus_byteenable = bus_if.byteenable;

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam time half_period  = 10ns;  // 20 ns clock
    localparam int  reset_cycles = 8;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Power-on reset released just after a rising edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

// File: testbench/mips_system_sva.sv
`timescale 1ns/10ps

module mips_system_sva
    import avalon_bus_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     active,
    input addr_t    address,
    input logic     read,
    input logic     write,
    input data_t    writedata,
    input byte_en_t byteenable,
    input logic     waitrequest
);

    int assert_errors = 0;  // Failed assertions so far

    a_read_write_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(read && write)
    ) else begin
        $error("read and write high in the same cycle");
        assert_errors++;
    end

    // Request held while the slave stretches the transfer
    a_request_stable: assert property (
        @(posedge clk) disable iff (rst)
        (read || write) && waitrequest |=> $stable(address) && $stable(read)
            && $stable(write) && $stable(writedata) && $stable(byteenable)
    ) else begin
        $error("bus request changed while waitrequest was high");
        assert_errors++;
    end

    a_inactive_in_reset: assert property (
        @(posedge clk) rst |=> !active
    ) else begin
        $error("active high during reset");
        assert_errors++;
    end

endmodule

bind mips_system mips_system_sva i_sva (
    .clk         (clk),
    .rst         (rst),
    .active      (active),
    .address     (bus_if.address),
    .read        (bus_if.read),
    .write       (bus_if.write),
    .writedata   (bus_if.writedata),
    .byteenable  (bus_if.byteenable),
    .waitrequest (bus_if.waitrequest)
);

// File: testbench/mips_system_tb.sv
`timescale 1ns/10ps

module mips_system_tb
    import mips_isa_pkg::*;
    import avalon_bus_pkg::*;
();

    localparam addr_t prog_base   = 32'd4;
    localparam addr_t data_base   = 32'h200;
    localparam int    run_limit   = 600;  // Cycles for a whole program
    localparam int    short_limit = 40;

    localparam logic [4:0] r_zero = 5'd0;
    localparam logic [4:0] r_v0   = 5'd2;
    localparam logic [4:0] r_t0   = 5'd8;
    localparam logic [4:0] r_t1   = 5'd9;
    localparam logic [4:0] r_t2   = 5'd10;
    localparam logic [4:0] r_t3   = 5'd11;
    localparam logic [4:0] r_t4   = 5'd12;

    logic     clk;
    logic     por_rst;
    logic     test_rst;
    logic     rst;
    logic     start;
    logic     load_en;
    addr_t    load_addr;
    data_t    load_data;
    logic     active;
    data_t    register_v0;
    addr_t    bus_address;
    logic     bus_read;
    logic     bus_write;
    data_t    bus_writedata;
    byte_en_t bus_byteenable;

    data_t program_words[$];

    assign rst = por_rst || test_rst;  // Extra reset between programs

    tb_clock_gen i_clock_gen (
        .clk (clk),
        .rst (por_rst)
    );

    mips_system #(
        .reset_vector  (prog_base),
        .ram_addr_bits (8),
        .wait_cycles   (1)
    ) i_dut (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .active         (active),
        .register_v0    (register_v0),
        .bus_address    (bus_address),
        .bus_read       (bus_read),
        .bus_write      (bus_write),
        .bus_writedata  (bus_writedata),
        .bus_byteenable (bus_byteenable)
    );

    function automatic data_t encode_imm(input opcode_t op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic data_t encode_reg(input funct_t fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd);
        return {op_special, rs, rt, rd, 5'd0, fn};
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "Stopped at the first error");
    endtask

    // Stop at the first failing bus or reset assertion
    always @(i_dut.i_sva.assert_errors) begin
        if (i_dut.i_sva.assert_errors != 0) begin
            report_failure("A bus or reset assertion failed");
        end
    end

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("FAIL t=%0t %s expected %h actual %h",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic check_byte_en(input string name, input byte_en_t expected,
                                 input byte_en_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("FAIL t=%0t %s expected %b actual %b",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("FAIL t=%0t %s expected %b actual %b",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic wait_for_halt(input int limit);
        int n;
        for (n = 0; n < limit && active; n++) begin
            @(negedge clk);
        end
        if (active) begin
            report_failure($sformatf("Timeout: the program did not halt in %0d cycles", limit));
        end
    endtask

    task automatic wait_for_write(input int limit);
        int n;
        for (n = 0; n < limit && !bus_write; n++) begin
            @(negedge clk);
        end
        if (!bus_write) begin
            report_failure("Timeout: no bus write was seen");
        end
    endtask

    task automatic wait_for_write_end(input int limit);
        int n;
        for (n = 0; n < limit && bus_write; n++) begin
            @(negedge clk);
        end
        if (bus_write) begin
            report_failure("Timeout: a bus write never completed");
        end
    endtask

    task automatic wait_for_fetch(input addr_t addr, input int limit);
        int n;
        for (n = 0; n < limit && !(bus_read && bus_address == addr); n++) begin
            @(negedge clk);
        end
        if (!(bus_read && bus_address == addr)) begin
            report_failure($sformatf("Timeout: no fetch from address %h", addr));
        end
    endtask

    task automatic apply_reset();
        int n;
        for (n = 0; n < short_limit && rst; n++) begin
            @(negedge clk);
        end
        if (rst) begin
            report_failure("Timeout: reset was never released");
        end
        @(posedge clk);
        #2;
        test_rst = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        test_rst = 1'b0;
    endtask

    // One word per cycle through the loader port
    task automatic load_program(input addr_t base);
        int i;
        for (i = 0; i < program_words.size(); i++) begin
            @(posedge clk);
            #2;
            load_en   = 1'b1;
            load_addr = base + addr_t'(4 * i);
            load_data = program_words[i];
        end
        @(posedge clk);
        #2;
        load_en = 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #2;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic launch_program();
        apply_reset();
        load_program(prog_base);
        pulse_start();
        @(negedge clk);
        check_bit("active", 1'b1, active);
    endtask

    task automatic verify_reset_state();
        apply_reset();
        @(negedge clk);
        check_bit("active", 1'b0, active);
        check_bit("bus_read", 1'b0, bus_read);
        check_bit("bus_write", 1'b0, bus_write);
        check_data("register_v0", 32'd0, register_v0);
    endtask

    task automatic arithmetic_program();
        program_words.delete();
        program_words.push_back(encode_imm(op_addiu, r_zero, r_v0, 16'h0001));
        program_words.push_back(encode_imm(op_addiu, r_v0, r_v0, 16'h0020));
        program_words.push_back(encode_imm(op_addiu, r_v0, r_v0, 16'h0010));
        program_words.push_back(encode_reg(fn_jr, r_zero, r_zero, r_zero));
        launch_program();
        wait_for_halt(run_limit);
        check_data("register_v0", 32'h1 + 32'h20 + 32'h10, register_v0);
    endtask

    task automatic random_immediates();
        logic [14:0] imm [5];
        data_t       model;
        int          i;
        for (i = 0; i < 5; i++) begin
            imm[i] = 15'($urandom);  // Kept positive so addiu does not sign extend
        end
        program_words.delete();
        program_words.push_back(encode_imm(op_addiu, r_zero, r_t0, {1'b0, imm[0]}));
        program_words.push_back(encode_imm(op_addiu, r_zero, r_t1, {1'b0, imm[1]}));
        program_words.push_back(encode_imm(op_addiu, r_zero, r_t2, {1'b0, imm[2]}));
        program_words.push_back(encode_imm(op_addiu, r_zero, r_t3, {1'b0, imm[3]}));
        program_words.push_back(encode_imm(op_addiu, r_zero, r_t4, {1'b0, imm[4]}));
        program_words.push_back(encode_reg(fn_addu, r_t0, r_t1, r_v0));
        program_words.push_back(encode_reg(fn_and, r_v0, r_t2, r_v0));
        program_words.push_back(encode_reg(fn_or, r_v0, r_t3, r_v0));
        program_words.push_back(encode_reg(fn_subu, r_v0, r_t4, r_v0));
        program_words.push_back(encode_reg(fn_jr, r_zero, r_zero, r_zero));
        // Same operations as the program in 32-bit arithmetic
        model = data_t'(imm[0]) + data_t'(imm[1]);
        model = model & data_t'(imm[2]);
        model = model | data_t'(imm[3]);
        model = model - data_t'(imm[4]);  // May wrap below zero
        launch_program();
        wait_for_halt(run_limit);
        check_data("register_v0", model, register_v0);
    endtask

    task automatic store_and_load();
        logic [15:0] word_imm;
        logic [7:0]  byte_val;
        logic [1:0]  lane;
        byte_en_t    lane_en;
        data_t       word_val;
        data_t       merged;
        word_imm = 16'($urandom);
        byte_val = 8'($urandom);
        lane     = 2'($urandom);
        lane_en  = '0;
        lane_en[lane] = 1'b1;  // Only the addressed byte
        word_val = {{16{word_imm[15]}}, word_imm};  // addiu sign extends
        merged   = word_val;
        merged[8*lane +: 8] = byte_val;
        program_words.delete();
        program_words.push_back(encode_imm(op_addiu, r_zero, r_t0, data_base[15:0]));
        program_words.push_back(encode_imm(op_addiu, r_zero, r_t1, word_imm));
        program_words.push_back(encode_imm(op_sw, r_t0, r_t1, 16'd0));
        program_words.push_back(encode_imm(op_addiu, r_zero, r_t2, {8'h00, byte_val}));
        program_words.push_back(encode_imm(op_sb, r_t0, r_t2, {14'd0, lane}));
        program_words.push_back(encode_imm(op_lw, r_t0, r_v0, 16'd0));
        program_words.push_back(encode_reg(fn_jr, r_zero, r_zero, r_zero));
        launch_program();
        wait_for_write(run_limit);  // sw
        check_data("bus_address", data_base, bus_address);
        check_byte_en("bus_byteenable", byte_en_word, bus_byteenable);
        check_data("bus_writedata", word_val, bus_writedata);
        wait_for_write_end(short_limit);
        wait_for_write(run_limit);  // sb
        check_data("bus_address", data_base + addr_t'(lane), bus_address);
        check_byte_en("bus_byteenable", lane_en, bus_byteenable);
        check_data("bus_writedata", {4{byte_val}}, bus_writedata);
        wait_for_halt(run_limit);
        check_data("register_v0", merged, register_v0);
    endtask

    task automatic branch_program();
        program_words.delete();
        program_words.push_back(encode_imm(op_addiu, r_zero, r_v0, 16'h0001));
        program_words.push_back(encode_imm(op_addiu, r_zero, r_t0, 16'd5));
        program_words.push_back(encode_imm(op_addiu, r_zero, r_t1, 16'd5));
        program_words.push_back(encode_imm(op_beq, r_t0, r_t1, 16'd1));  // Taken
        program_words.push_back(encode_imm(op_addiu, r_v0, r_v0, 16'h0010));
        program_words.push_back(encode_imm(op_addiu, r_zero, r_t1, 16'd6));
        program_words.push_back(encode_imm(op_beq, r_t0, r_t1, 16'd1));  // Not taken
        program_words.push_back(encode_imm(op_addiu, r_v0, r_v0, 16'h0100));
        program_words.push_back(encode_reg(fn_jr, r_zero, r_zero, r_zero));
        launch_program();
        wait_for_halt(run_limit);
        check_data("register_v0", 32'h1 + 32'h100, register_v0);
    endtask

    task automatic jump_register_program();
        addr_t target;
        target = prog_base + 32'd16;  // Fifth word of the program
        program_words.delete();
        program_words.push_back(encode_imm(op_addiu, r_zero, r_v0, 16'h0003));
        program_words.push_back(encode_imm(op_addiu, r_zero, r_t0, target[15:0]));
        program_words.push_back(encode_reg(fn_jr, r_t0, r_zero, r_zero));
        program_words.push_back(encode_imm(op_addiu, r_v0, r_v0, 16'h0040));
        program_words.push_back(encode_imm(op_addiu, r_v0, r_v0, 16'h0200));
        program_words.push_back(encode_reg(fn_jr, r_zero, r_zero, r_zero));
        launch_program();
        wait_for_fetch(target, run_limit);
        check_bit("active", 1'b1, active);  // Nonzero jr does not halt
        wait_for_halt(run_limit);
        check_data("register_v0", 32'h3 + 32'h200, register_v0);
    endtask

    initial begin
        start     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        test_rst  = 1'b0;
        void'($urandom(17736));
        verify_reset_state();
        arithmetic_program();
        random_immediates();
        store_and_load();
        branch_program();
        jump_register_program();
        if (i_dut.i_sva.assert_errors == 0) begin
            $display("All checks passed");
        end else begin
            report_failure("A bus or reset assertion failed during the run");
        end
        $finish;
    end

endmodule

// File: compile.f
src/mips_isa_pkg.sv
src/avalon_bus_pkg.sv
src/avalon_mm_if.sv
src/mips_alu.sv
src/mips_reg_file.sv
src/mips_cpu.sv
src/avalon_ram.sv
src/mips_system.sv
testbench/tb_clock_gen.sv
testbench/mips_system_sva.sv
testbench/mips_system_tb.sv

// File: Bender.yml
package:
  name: mips_system

sources:
  - src/mips_isa_pkg.sv
  - src/avalon_bus_pkg.sv
  - src/avalon_mm_if.sv
  - src/mips_alu.sv
  - src/mips_reg_file.sv
  - src/mips_cpu.sv
  - src/avalon_ram.sv
  - src/mips_system.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/mips_system_sva.sv
      - testbench/mips_system_tb.sv
